/* xadc_cfg.svh */
`ifndef XADC_CFG_SVH
`define XADC_CFG_SVH

////////////////////////////////////////
// udp frame and word packing
////////////////////////////////////////

// words per udp frame before end_of_data
`define XADC_MAX_WORDS        150
// 12-bit results per 64-bit fifo word
`define XADC_SAMPLES_PER_WORD 5
// vmm index field in bits 63:60
`define XADC_HDR_W            4

// sweep over all vmms when vmm_id[3:0] >= 8
`define XADC_NUM_VMM          8
`define XADC_ALL_VMM_ID       8

`endif

/* xadc_pkg.sv */
package xadc_pkg;

    typedef logic [11:0] sample_t;       // one converter result
    typedef logic [63:0] word_t;         // one data fifo word
    typedef logic [2:0]  vmm_idx_t;
    typedef logic [4:0]  adc_channel_t;
    typedef logic [10:0] sample_count_t; // samples per vmm set
    typedef logic [17:0] delay_t;        // gap between samples
    typedef logic [8:0]  word_count_t;   // words in current frame
    typedef logic [11:0] packet_len_t;

    typedef enum logic [2:0] {
        seq_idle,
        seq_request,
        seq_wait_sample,
        seq_gap,
        seq_wait_write,
        seq_wait_release
    } seq_state_t;

    typedef enum logic [1:0] {
        rd_idle,
        rd_convert,
        rd_wait_done
    } rd_state_t;

endpackage

/* sample_sequencer.sv */
`timescale 1ns/1ns
`include "xadc_cfg.svh"

module sample_sequencer
    import xadc_pkg::*;
(
    input  logic          clk200,
    input  logic          rst,
    input  logic          data_in_rdy,
    input  logic [15:0]   vmm_id,
    input  sample_count_t sample_size,
    input  delay_t        delay_in,
    input  logic          udp_done,
    input  logic          sample_valid,
    input  logic          set_written,
    output logic          sample_req,
    output vmm_idx_t      req_vmm,
    output logic          req_last,
    output logic          xadc_busy
);

    localparam vmm_idx_t last_vmm = vmm_idx_t'(`XADC_NUM_VMM - 1);

    seq_state_t    state;
    vmm_idx_t      vmm_sel;      // vmm being sampled
    logic          sweep;        // all eight vmms in turn
    logic          start_sweep;
    sample_count_t smp_cnt;      // samples requested in this set
    delay_t        gap_cnt;

    assign start_sweep = (vmm_id[3:0] >= 4'(`XADC_ALL_VMM_ID));

    // request lasts exactly the one cycle spent in seq_request
    assign sample_req = (state == seq_request);
    assign req_vmm    = vmm_sel;
    assign req_last   = (smp_cnt + 1'b1 == sample_size);

    ////////////////////////////////////////
    // run control
    ////////////////////////////////////////

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            state     <= seq_idle;
            vmm_sel   <= '0;
            sweep     <= 1'b0;
            smp_cnt   <= '0;
            gap_cnt   <= '0;
            xadc_busy <= 1'b0;
        end
        else
        begin
            case (state)
                seq_idle:
                begin
                    if (data_in_rdy)
                    begin
                        xadc_busy <= 1'b1;
                        sweep     <= start_sweep;
                        vmm_sel   <= start_sweep ? '0 : vmm_id[2:0];
                        smp_cnt   <= '0;
                        state     <= seq_request;
                    end
                end

                seq_request:
                begin
                    smp_cnt <= smp_cnt + 1'b1;
                    state   <= seq_wait_sample;
                end

                seq_wait_sample:
                begin
                    if (sample_valid)
                    begin
                        if (smp_cnt == sample_size)    // set complete
                            state <= seq_wait_write;
                        else
                        begin
                            gap_cnt <= '0;
                            state   <= seq_gap;
                        end
                    end
                end

                seq_gap:
                begin
                    if (gap_cnt == delay_in)
                        state <= seq_request;
                    else
                        gap_cnt <= gap_cnt + 1'b1;
                end

                seq_wait_write:
                begin
                    if (set_written)
                    begin
                        if (sweep && vmm_sel != last_vmm)
                        begin
                            vmm_sel <= vmm_sel + 1'b1;  // next vmm in sweep
                            smp_cnt <= '0;
                            state   <= seq_request;
                        end
                        else
                            state <= seq_wait_release;
                    end
                end

                seq_wait_release:
                begin
                    // old command gone and udp frame sent
                    if (!data_in_rdy && udp_done)
                    begin
                        xadc_busy <= 1'b0;
                        state     <= seq_idle;
                    end
                end

                default: state <= seq_idle;
            endcase
        end
    end

endmodule

/* channel_reader.sv */
`timescale 1ns/1ns

module channel_reader
    import xadc_pkg::*;
(
    input  logic         clk200,
    input  logic         rst,
    input  logic         sample_req,
    input  vmm_idx_t     req_vmm,
    input  logic         req_last,
    input  logic         conv_done,
    input  sample_t      conv_result,
    output logic         conv_start,
    output adc_channel_t conv_channel,
    output logic         sample_valid,
    output sample_t      sample,
    output vmm_idx_t     sample_vmm,
    output logic         sample_last
);

    rd_state_t state;

    assign conv_start = (state == rd_convert);    // one cycle after the request

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            state        <= rd_idle;
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= 1'b0;
            case (state)
                rd_idle:
                    if (sample_req)
                        state <= rd_convert;
                rd_convert:
                    state <= rd_wait_done;
                rd_wait_done:
                begin
                    if (conv_done)
                    begin
                        sample_valid <= 1'b1;
                        state        <= rd_idle;
                    end
                end
                default: state <= rd_idle;
            endcase
        end
    end

    // channel and tags held from the request until the result leaves
    always_ff @(posedge clk200)
    begin
        if (state == rd_idle && sample_req)
        begin
            conv_channel <= adc_channel_t'(req_vmm);  // monitor channel n for vmm n
            sample_vmm   <= req_vmm;
            sample_last  <= req_last;
        end
        if (state == rd_wait_done && conv_done)
            sample <= conv_result;
    end

endmodule

/* packet_packer.sv */
`timescale 1ns/1ns
`include "xadc_cfg.svh"

module packet_packer
    import xadc_pkg::*;
(
    input  logic     clk200,
    input  logic     rst,
    input  logic     sample_valid,
    input  sample_t  sample,
    input  vmm_idx_t sample_vmm,
    input  logic     sample_last,
    output logic     word_valid,
    output word_t    word,
    output logic     word_last
);

    localparam int slot_w    = $bits(sample_t);
    localparam int payload_w = `XADC_SAMPLES_PER_WORD * slot_w;
    localparam int hdr_w     = `XADC_HDR_W;
    localparam int last_slot = `XADC_SAMPLES_PER_WORD - 1;

    logic [2:0]           slot;          // next free slot
    logic [payload_w-1:0] payload;       // word under assembly
    logic [payload_w-1:0] payload_next;
    logic [hdr_w-1:0]     header;
    logic                 flush;

    ////////////////////////////////////////
    // slot placement
    ////////////////////////////////////////

    always_comb
    begin
        payload_next = payload;
        payload_next[slot*slot_w +: slot_w] = sample;
    end

    assign header = hdr_w'(sample_vmm);
    // full word, or last sample of the set with zeros above it
    assign flush  = (slot == 3'(last_slot)) || sample_last;

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            slot       <= '0;
            payload    <= '0;
            word_valid <= 1'b0;
        end
        else
        begin
            word_valid <= 1'b0;
            if (sample_valid)
            begin
                if (flush)
                begin
                    word_valid <= 1'b1;
                    slot       <= '0;
                    payload    <= '0;
                end
                else
                begin
                    slot    <= slot + 1'b1;
                    payload <= payload_next;
                end
            end
        end
    end

    // outgoing word
    always_ff @(posedge clk200)
    begin
        if (sample_valid && flush)
        begin
            word      <= {header, payload_next};
            word_last <= sample_last;
        end
    end

endmodule

/* fifo_writer.sv */
`timescale 1ns/1ns
`include "xadc_cfg.svh"

module fifo_writer
    import xadc_pkg::*;
(
    input  logic        clk200,
    input  logic        rst,
    input  logic        word_valid,
    input  word_t       word,
    input  logic        word_last,
    output logic        data_fifo_enable,
    output word_t       fifo_bus,
    output packet_len_t packet_len,
    output logic        end_of_data,
    output logic        set_written
);

    word_count_t frame_cnt;    // words already in this frame
    word_count_t word_no;      // 1-based index of incoming word
    logic        frame_end;
    logic [1:0]  eod_left;     // extra cycles of end_of_data

    assign word_no   = frame_cnt + 1'b1;
    assign frame_end = word_last || (word_no == word_count_t'(`XADC_MAX_WORDS));

    ////////////////////////////////////////
    // strobes and frame count
    ////////////////////////////////////////

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            data_fifo_enable <= 1'b0;
            set_written      <= 1'b0;
            end_of_data      <= 1'b0;
            eod_left         <= '0;
            frame_cnt        <= '0;
        end
        else
        begin
            data_fifo_enable <= word_valid;
            set_written      <= word_valid && word_last;

            if (word_valid)
                frame_cnt <= frame_end ? '0 : word_no;   // restart after frame end

            // held 3 cycles so the 125 MHz side sees it
            if (word_valid && frame_end)
            begin
                end_of_data <= 1'b1;
                eod_left    <= 2'd2;
            end
            else if (eod_left != 2'd0)
                eod_left <= eod_left - 1'b1;
            else
                end_of_data <= 1'b0;
        end
    end

    always_ff @(posedge clk200)
    begin
        if (word_valid)
        begin
            fifo_bus   <= word;
            packet_len <= packet_len_t'(word_no);
        end
    end

endmodule

/* xadc_sampler.sv */
`timescale 1ns/1ns

module xadc_sampler
    import xadc_pkg::*;
(
    input  logic          clk200,
    input  logic          rst,
    input  logic          data_in_rdy,
    input  logic [15:0]   vmm_id,
    input  sample_count_t sample_size,
    input  delay_t        delay_in,
    input  logic          udp_done,
    input  logic          conv_done,
    input  sample_t       conv_result,
    output logic          conv_start,
    output adc_channel_t  conv_channel,
    output logic          data_fifo_enable,
    output word_t         fifo_bus,
    output packet_len_t   packet_len,
    output logic          end_of_data,
    output logic          xadc_busy
);

    // sequencer to reader
    logic     sample_req;
    vmm_idx_t req_vmm;
    logic     req_last;

    // reader to packer and sequencer
    logic     sample_valid;
    sample_t  sample;
    vmm_idx_t sample_vmm;
    logic     sample_last;

    // packer to writer
    logic     word_valid;
    word_t    word;
    logic     word_last;

    logic     set_written;    // last word of a vmm set is in the fifo

    sample_sequencer u_sequencer (
        .clk200(clk200), .rst(rst),
        .data_in_rdy(data_in_rdy), .vmm_id(vmm_id),
        .sample_size(sample_size), .delay_in(delay_in), .udp_done(udp_done),
        .sample_valid(sample_valid), .set_written(set_written),
        .sample_req(sample_req), .req_vmm(req_vmm), .req_last(req_last),
        .xadc_busy(xadc_busy)
    );

    channel_reader u_reader (
        .clk200(clk200), .rst(rst),
        .sample_req(sample_req), .req_vmm(req_vmm), .req_last(req_last),
        .conv_done(conv_done), .conv_result(conv_result),
        .conv_start(conv_start), .conv_channel(conv_channel),
        .sample_valid(sample_valid), .sample(sample),
        .sample_vmm(sample_vmm), .sample_last(sample_last)
    );

    packet_packer u_packer (
        .clk200(clk200), .rst(rst),
        .sample_valid(sample_valid), .sample(sample),
        .sample_vmm(sample_vmm), .sample_last(sample_last),
        .word_valid(word_valid), .word(word), .word_last(word_last)
    );

    fifo_writer u_writer (
        .clk200(clk200), .rst(rst),
        .word_valid(word_valid), .word(word), .word_last(word_last),
        .data_fifo_enable(data_fifo_enable), .fifo_bus(fifo_bus),
        .packet_len(packet_len), .end_of_data(end_of_data),
        .set_written(set_written)
    );

endmodule

/* xadc_sampler_checker.sv */
`timescale 1ns/1ns

module xadc_sampler_checker
(
    input logic clk200,
    input logic rst,
    input logic conv_start,
    input logic conv_done,
    input logic data_fifo_enable,
    input logic xadc_busy,
    input logic end_of_data
);

    logic       conv_pending;    // start seen without its done
    logic [2:0] eod_len;         // cycles end_of_data has been high

    always_ff @(posedge clk200)
    begin
        if (rst)
        begin
            conv_pending <= 1'b0;
            eod_len      <= '0;
        end
        else
        begin
            if (conv_start)
                conv_pending <= 1'b1;
            else if (conv_done)
                conv_pending <= 1'b0;
            eod_len <= end_of_data ? eod_len + 1'b1 : '0;
        end
    end

    ////////////////////////////////////////
    // strobes and handshakes
    ////////////////////////////////////////

    enable_pulse: assert property (@(posedge clk200) disable iff (rst)
        data_fifo_enable |=> !data_fifo_enable)
        else $error("data_fifo_enable held longer than one cycle");

    start_pulse: assert property (@(posedge clk200) disable iff (rst)
        conv_start |=> !conv_start)
        else $error("conv_start held longer than one cycle");

    single_conversion: assert property (@(posedge clk200) disable iff (rst)
        conv_start |-> !conv_pending)
        else $error("conv_start while a conversion is still pending");

    enable_when_busy: assert property (@(posedge clk200) disable iff (rst)
        data_fifo_enable |-> xadc_busy)
        else $error("fifo write outside a busy run");

    // end_of_data stretched to exactly three cycles
    eod_not_long: assert property (@(posedge clk200) disable iff (rst)
        end_of_data |-> eod_len < 3'd3)
        else $error("end_of_data longer than three cycles");

    eod_not_short: assert property (@(posedge clk200) disable iff (rst)
        $fell(end_of_data) |-> eod_len == 3'd3)
        else $error("end_of_data shorter than three cycles");

endmodule

/* tb_xadc_sampler.sv */
`timescale 1ns/1ns

module tb_xadc_sampler
    import xadc_pkg::*;
();

    localparam int frame_words = 150;
    localparam int slots       = 5;    // samples per fifo word

    logic          clk200;
    logic          rst;
    logic          data_in_rdy;
    logic [15:0]   vmm_id;
    sample_count_t sample_size;
    delay_t        delay_in;
    logic          udp_done;
    logic          conv_done;
    sample_t       conv_result;
    logic          conv_start;
    adc_channel_t  conv_channel;
    logic          data_fifo_enable;
    word_t         fifo_bus;
    packet_len_t   packet_len;
    logic          end_of_data;
    logic          xadc_busy;

    // converter results in order as {channel, result}
    logic [16:0] conv_q[$];

    // run description written by the stimulus
    string test_name;
    int    run_no = 0;
    int    run_first_vmm;
    int    run_size;
    logic  run_sweep;

    // reference model state kept by the scoreboard
    int seen_run   = 0;
    int exp_vmm    = 0;
    int set_cnt    = 0;
    int frame_cnt  = 0;
    int strobes    = 0;
    int sets_total = 0;
    int mismatches = 0;
    int failures   = 0;    // stimulus side checks

    xadc_sampler u_xadc_sampler (.*);

    bind xadc_sampler xadc_sampler_checker u_checker (
        .clk200(clk200), .rst(rst),
        .conv_start(conv_start), .conv_done(conv_done),
        .data_fifo_enable(data_fifo_enable), .xadc_busy(xadc_busy),
        .end_of_data(end_of_data)
    );

    initial
    begin
        clk200 = 1'b0;
        forever #2 clk200 = ~clk200;
    end

    task automatic tick();
        @(posedge clk200);
        #1;
    endtask

    function automatic void show_mismatch(input string what, input logic [63:0] exp_v,
                                          input logic [63:0] act_v);
        $display("Mismatch %s %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
    endfunction

    ////////////////////////////////////////
    // converter model
    ////////////////////////////////////////

    initial
    begin : converter
        adc_channel_t ch;
        int           lat;
        sample_t      res;
        conv_done   = 1'b0;
        conv_result = '0;
        forever
        begin
            tick();
            if (conv_start)
            begin
                ch  = conv_channel;
                lat = $urandom_range(8, 1);    // conversion time
                repeat (lat) @(posedge clk200);
                #1;
                res         = sample_t'($urandom);
                conv_done   = 1'b1;
                conv_result = res;
                conv_q.push_back({ch, res});
                tick();
                conv_done = 1'b0;
            end
        end
    end

    // rebuild one fifo word from the converted samples
    task automatic check_strobe();
        word_t       exp_word;
        logic [16:0] item;
        int          slot;
        logic        set_end;
        logic        frame_end;
        if (seen_run != run_no)    // first word of a new run
        begin
            seen_run = run_no;
            exp_vmm  = run_first_vmm;
            set_cnt  = 0;
        end
        exp_word = '0;
        slot     = 0;
        set_end  = 1'b0;
        while (slot < slots && !set_end && conv_q.size() > 0)
        begin
            item = conv_q.pop_front();
            if (item[16:12] != adc_channel_t'(exp_vmm))
            begin
                mismatches++;
                show_mismatch("conv_channel", 64'(exp_vmm), 64'(item[16:12]));
            end
            exp_word[slot*12 +: 12] = item[11:0];
            slot++;
            set_cnt++;
            set_end = (set_cnt == run_size);
        end
        if (slot < slots && !set_end)
        begin
            mismatches++;
            $display("%s: fifo word written before its samples were converted", test_name);
        end
        exp_word[63:60] = 4'(exp_vmm);
        frame_cnt++;
        frame_end = set_end || frame_cnt == frame_words;

        if (fifo_bus !== exp_word)
        begin
            mismatches++;
            show_mismatch("fifo_bus", exp_word, fifo_bus);
        end
        if (packet_len !== packet_len_t'(frame_cnt))
        begin
            mismatches++;
            show_mismatch("packet_len", 64'(frame_cnt), 64'(packet_len));
        end
        if (end_of_data !== frame_end)
        begin
            mismatches++;
            show_mismatch("end_of_data", 64'(frame_end), 64'(end_of_data));
        end

        if (frame_end)
            frame_cnt = 0;
        if (set_end)
        begin
            set_cnt = 0;
            sets_total++;
            if (run_sweep)
                exp_vmm++;    // sweep goes 0 to 7
        end
        strobes++;
    endtask

    initial
    begin : scoreboard
        forever
        begin
            tick();
            if (data_fifo_enable)
                check_strobe();
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic hold_check(input int cycles);
        repeat (cycles)
        begin
            tick();
            if (!xadc_busy)
            begin
                failures++;
                $display("%s: xadc_busy dropped while the run was still held", test_name);
            end
        end
    endtask

    task automatic do_run(input string name, input logic [15:0] id, input int size,
                          input int gap, input int hold);
        int n_vmm;
        int words0;
        int sets0;
        int limit;
        int t;
        test_name     = name;
        run_sweep     = (id[3:0] >= 4'd8);
        n_vmm         = run_sweep ? 8 : 1;
        run_first_vmm = run_sweep ? 0 : int'(id[2:0]);
        run_size      = size;
        run_no++;
        words0 = strobes;
        sets0  = sets_total;
        limit  = n_vmm * size * (gap + 20) + 200;

        vmm_id      = id;
        sample_size = sample_count_t'(size);
        delay_in    = delay_t'(gap);
        udp_done    = 1'b0;
        data_in_rdy = 1'b1;
        tick();
        if (!xadc_busy)
        begin
            failures++;
            $display("%s: xadc_busy did not rise one cycle after data_in_rdy", name);
        end

        t = 0;
        while (sets_total - sets0 < n_vmm && t < limit)
        begin
            tick();
            t++;
        end
        if (t >= limit)
        begin
            failures++;
            $display("%s: timeout, %0d of %0d vmm sets written", name,
                     sets_total - sets0, n_vmm);
        end

        udp_done = 1'b1;    // frame sent but command still up
        hold_check(hold);
        data_in_rdy = 1'b0;
        udp_done    = 1'b0;
        hold_check(hold);
        udp_done = 1'b1;
        tick();    // busy drops one cycle after both levels release
        if (xadc_busy)
        begin
            failures++;
            $display("%s: xadc_busy did not fall one cycle after release", name);
        end

        if (strobes - words0 != n_vmm * ((size + slots - 1) / slots))
        begin
            failures++;
            show_mismatch("word count", 64'(n_vmm * ((size + slots - 1) / slots)),
                          64'(strobes - words0));
        end
        if (conv_q.size() != 0)
        begin
            failures++;
            $display("%s: %0d converter results never written", name, conv_q.size());
        end
    endtask

    initial
    begin : stimulus
        logic [15:0] id;
        int          size;
        int          gap;
        rst         = 1'b1;
        data_in_rdy = 1'b0;
        vmm_id      = '0;
        sample_size = '0;
        delay_in    = '0;
        udp_done    = 1'b0;
        void'($urandom(32'h4453));

        repeat (16) tick();
        rst = 1'b0;
        if (xadc_busy || conv_start || data_fifo_enable || end_of_data)
        begin
            failures++;
            $display("outputs not low after reset");
        end
        repeat (4) tick();

        do_run("single_vmm", 16'd3, 7, 4, 2);
        do_run("sweep", 16'd9, 3, 2, 2);
        do_run("frame_split", 16'd5, 760, 0, 2);
        do_run("release", 16'd1, 4, 1, 25);    // long hold on both release levels
        repeat (6)
        begin
            id   = 16'($urandom);
            size = $urandom_range(40, 1);
            gap  = $urandom_range(20, 0);
            do_run("random", id, size, gap, 3);
        end

        repeat (8) tick();
        $display("words checked %0d, mismatches %0d, other failures %0d",
                 strobes, mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
xadc_pkg.sv
sample_sequencer.sv
channel_reader.sv
packet_packer.sv
fifo_writer.sv
xadc_sampler.sv
xadc_sampler_checker.sv
tb_xadc_sampler.sv

/* run_sim.sh */
#!/bin/sh
# verilator build and run of tb_xadc_sampler, fails on a fail line in sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_xadc_sampler -f compile.f \
        -o tb_xadc_sampler > build.log 2>&1 \
    && ./obj_dir/tb_xadc_sampler > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "Verification failed" sim.log \
    || { cat build.log sim.log 2>/dev/null; echo "simulation run not clean"; exit 1; }

echo "simulation run clean"
